// ==== sim.f ====
source/alu_pkg.sv
source/instr_decoder.sv
source/op_queue.sv
source/alu_exec.sv
source/alu_subsystem.sv
bench/tb_alu_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_alu_subsystem -f sim.f &&
{ out="$(./obj_dir/Vtb_alu_subsystem 2>&1)"; echo "$out"; } &&
echo "$out" | grep -qF '*** TEST PASSED ***' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== bench/alu_input.txt ====
# name instr rs1 rs2 pc exp_result exp_target exp_equal exp_greater (values in hex)
# vectors run in file order; the target holds its value until the next jal or jalr
add        003100B3 7FFFFFFF 00000001 00001000 80000000 00000000 0 1
sub        403100B3 00000000 00000001 00001000 FFFFFFFF 00000000 0 0
and        003170B3 F0F0F0F0 0FF00FF0 00001000 00F000F0 00000000 0 1
or         003160B3 F0F0F0F0 0FF00FF0 00001000 FFF0FFF0 00000000 0 1
xor        003140B3 12345678 12345678 00001000 00000000 00000000 1 0
sll        003110B3 00000001 00000023 00001000 00000008 00000000 0 0
srl        003150B3 80000000 00000004 00001000 08000000 00000000 0 1
sra        403150B3 80000000 00000004 00001000 F8000000 00000000 0 1
slt        003120B3 FFFFFFFF 00000001 00001000 00000001 00000000 0 1
slt_pos    003120B3 00000001 FFFFFFFF 00001000 00000000 00000000 0 0
sltu       003130B3 FFFFFFFF 00000001 00001000 00000000 00000000 0 1
addi_neg   FFB10093 00000003 00000000 00001000 FFFFFFFE 00000000 0 1
andi       0F017093 12345678 00000000 00001000 00000070 00000000 0 1
ori_neg    F0016093 00000012 00000000 00001000 FFFFFF12 00000000 0 1
xori_not   FFF14093 0000FFFF 00000000 00001000 FFFF0000 00000000 0 1
slli       00411093 0000000F 00000000 00001000 000000F0 00000000 0 1
srli       00815093 80000000 00000000 00001000 00800000 00000000 0 1
srai       40815093 80000000 00000000 00001000 FF800000 00000000 0 1
slti_neg   FFF12093 80000000 00000000 00001000 00000001 00000000 0 1
sltiu_max  FFF13093 FFFFFFFE 00000000 00001000 00000001 00000000 0 1
lui        123450B7 00000000 00000000 00001000 12345000 00000000 1 0
auipc_neg  FFFFF097 00000000 00000000 00002000 00001000 00000000 1 0
load_addr  FFC12083 00001000 00000000 00001000 00000FFC 00000000 0 1
store_addr 00312823 00001000 DEADBEEF 00001000 00001010 00000000 0 0
mul        023100B3 FFFFFFFF 00000003 00001000 FFFFFFFD 00000000 0 1
mulh       023110B3 80000000 80000000 00001000 40000000 00000000 1 0
mulhsu     023120B3 FFFFFFFF FFFFFFFF 00001000 FFFFFFFF 00000000 1 0
mulhu      023130B3 FFFFFFFF FFFFFFFF 00001000 FFFFFFFE 00000000 1 0
div        023140B3 FFFFFFF9 00000002 00001000 FFFFFFFD 00000000 0 1
div_zero   023140B3 00000005 00000000 00001000 FFFFFFFF 00000000 0 1
div_ovf    023140B3 80000000 FFFFFFFF 00001000 80000000 00000000 0 0
divu       023150B3 FFFFFFF9 00000002 00001000 7FFFFFFC 00000000 0 1
divu_zero  023150B3 00000005 00000000 00001000 FFFFFFFF 00000000 0 1
rem        023160B3 FFFFFFF9 00000002 00001000 FFFFFFFF 00000000 0 1
rem_zero   023160B3 FFFFFFF9 00000000 00001000 FFFFFFF9 00000000 0 1
rem_ovf    023160B3 80000000 FFFFFFFF 00001000 00000000 00000000 0 0
remu       023170B3 FFFFFFF9 00000002 00001000 00000001 00000000 0 1
remu_zero  023170B3 00000005 00000000 00001000 00000005 00000000 0 1
illegal    FFFFFFFF 00000005 00000005 00001000 00000000 00000000 1 0
jal_fwd    100000EF 00000000 00000000 00001000 00001004 00001100 1 0
add_hold   003100B3 00000001 00000002 00001008 00000003 00001100 0 0
jalr       00C100E7 00002001 00000000 00003000 00003004 0000200C 0 1
jal_back   FF9FF0EF 00000000 00000000 00004000 00004004 00003FF8 1 0
add_wrap   003100B3 FFFFFFFF 00000001 00004004 00000000 00003FF8 0 1

// ==== bench/tb_alu_subsystem.sv ====
`default_nettype none

module tb_alu_subsystem;
   import alu_pkg::*;

   localparam int timeout_cycles = 50;
   localparam int stream_len     = 20;

   logic            clk_i;
   logic            rst_i;
   logic            issue_i;
   logic [xlen-1:0] instr_i;
   logic [xlen-1:0] rs1_value_i;
   logic [xlen-1:0] rs2_value_i;
   logic [xlen-1:0] pc_i;
   logic            full_o;
   logic            result_valid_o;
   alu_result_t     result_o;

   // expected results in issue order
   alu_result_t     exp_q[$];
   string           name_q[$];
   logic [xlen-1:0] held_target;
   logic [31:0]     rng_state;
   int              pass_count;
   int              fail_count;
   bit              timed_out;
   bit              full_seen;

   alu_subsystem #(
      .queue_depth (4)
   ) alu_subsystem_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .issue_i        (issue_i),
      .instr_i        (instr_i),
      .rs1_value_i    (rs1_value_i),
      .rs2_value_i    (rs2_value_i),
      .pc_i           (pc_i),
      .full_o         (full_o),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

   always #10 clk_i = ~clk_i;

   always @(negedge clk_i) begin
      if (!rst_i && full_o) begin
         full_seen = 1'b1;
      end
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // holds the issue for exactly one cycle starting just after a rising edge
   task automatic drive_instr(input string name, input logic [31:0] instr,
                              input logic [31:0] rs1, input logic [31:0] rs2,
                              input logic [31:0] pc, input alu_result_t expected);
      issue_i     = 1'b1;
      instr_i     = instr;
      rs1_value_i = rs1;
      rs2_value_i = rs2;
      pc_i        = pc;
      exp_q.push_back(expected);
      name_q.push_back(name);
      @(posedge clk_i);
      #2;
   endtask

   task automatic collect_result();
      int          waited;
      bit          ok;
      string       name;
      alu_result_t expected;
      waited = 0;
      ok     = 1'b1;
      @(negedge clk_i);
      while (result_valid_o !== 1'b1 && waited < timeout_cycles) begin
         @(negedge clk_i);
         waited++;
      end
      name     = name_q.pop_front();
      expected = exp_q.pop_front();
      if (result_valid_o !== 1'b1) begin
         $display("timeout: no result for %s within %0d cycles", name, timeout_cycles);
         timed_out = 1'b1;
         fail_count++;
      end else begin
         if (result_o.result !== expected.result) begin
            $display("ERR %s result expected %h actual %h", name, expected.result,
                     result_o.result);
            ok = 1'b0;
         end
         if (result_o.target !== expected.target) begin
            $display("ERR %s target expected %h actual %h", name, expected.target,
                     result_o.target);
            ok = 1'b0;
         end
         if (result_o.equal !== expected.equal) begin
            $display("ERR %s equal expected %b actual %b", name, expected.equal,
                     result_o.equal);
            ok = 1'b0;
         end
         if (result_o.greater !== expected.greater) begin
            $display("ERR %s greater expected %b actual %b", name, expected.greater,
                     result_o.greater);
            ok = 1'b0;
         end
         if (ok) begin
            pass_count++;
            $display("pass %s", name);
         end else begin
            fail_count++;
            $display("fail %s", name);
         end
      end
   endtask

   // nothing may come out of the pipe before the first issue
   task automatic check_reset();
      bit ok;
      ok = 1'b1;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk_i);
         if (result_valid_o !== 1'b0) begin
            $display("ERR reset result_valid_o expected 0 actual %b", result_valid_o);
            ok = 1'b0;
         end
         if (full_o !== 1'b0) begin
            $display("ERR reset full_o expected 0 actual %b", full_o);
            ok = 1'b0;
         end
      end
      if (ok) begin
         pass_count++;
         $display("pass reset");
      end else begin
         fail_count++;
         $display("fail reset");
      end
   endtask

   task automatic run_file_vectors();
      int          fd;
      int          n;
      int          loaded;
      string       line;
      string       name;
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] pc;
      logic [31:0] exp_result;
      logic [31:0] exp_target;
      logic        exp_eq;
      logic        exp_gt;
      alu_result_t expected;
      loaded = 0;
      fd     = $fopen("bench/alu_input.txt", "r");
      if (fd == 0) begin
         $display("could not open bench/alu_input.txt");
         fail_count++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %b %b", name, instr, rs1, rs2, pc,
                           exp_result, exp_target, exp_eq, exp_gt);
               if (n != 9) begin
                  $display("could not parse vector line: %s", line);
                  fail_count++;
               end else begin
                  expected.result  = exp_result;
                  expected.target  = exp_target;
                  expected.equal   = exp_eq;
                  expected.greater = exp_gt;
                  held_target      = exp_target;
                  loaded++;
                  @(posedge clk_i);
                  #2;
                  drive_instr(name, instr, rs1, rs2, pc, expected);
                  issue_i = 1'b0;
                  collect_result();
               end
            end
         end
         $fclose(fd);
         if (loaded == 0) begin
            $display("no test vectors found in bench/alu_input.txt");
            fail_count++;
         end
      end
   endtask

   // random add and xor issued on consecutive cycles and checked as they drain
   task automatic run_stream();
      logic [31:0] a;
      logic [31:0] b;
      bit          use_xor;
      alu_result_t expected;
      full_seen = 1'b0;
      @(posedge clk_i);
      #2;
      fork
         begin
            for (int i = 0; i < stream_len; i++) begin
               rng_state = next_random(rng_state);
               a         = rng_state;
               rng_state = next_random(rng_state);
               b         = rng_state;
               use_xor   = rng_state[7];
               if (rng_state[3:0] == 4'd0) begin
                  b = a;
               end
               expected.result  = use_xor ? (a ^ b) : (a + b);
               expected.target  = held_target;
               expected.equal   = (a == b);
               expected.greater = (a > b);
               drive_instr($sformatf("stream_%0d", i), use_xor ? 32'h003140B3 : 32'h003100B3,
                           a, b, 32'h00005000 + 32'(i * 4), expected);
            end
            issue_i = 1'b0;
         end
         begin
            for (int j = 0; j < stream_len && !timed_out; j++) begin
               collect_result();
            end
         end
      join
      if (full_seen) begin
         $display("full_o went high during the back-to-back stream");
         fail_count++;
      end
   endtask

   initial begin
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      issue_i     = 1'b0;
      instr_i     = '0;
      rs1_value_i = '0;
      rs2_value_i = '0;
      pc_i        = '0;
      held_target = '0;
      rng_state   = 32'd75803;
      pass_count  = 0;
      fail_count  = 0;
      timed_out   = 1'b0;
      full_seen   = 1'b0;
      repeat (4) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      check_reset();
      run_file_vectors();
      if (!timed_out) begin
         run_stream();
      end
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/alu_subsystem.sv ====
`default_nettype none

module alu_subsystem #(
   parameter int unsigned queue_depth = 4
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     issue_i,
   input  logic [alu_pkg::xlen-1:0] instr_i,
   input  logic [alu_pkg::xlen-1:0] rs1_value_i,
   input  logic [alu_pkg::xlen-1:0] rs2_value_i,
   input  logic [alu_pkg::xlen-1:0] pc_i,
   output logic                     full_o,
   output logic                     result_valid_o,
   output alu_pkg::alu_result_t     result_o
);
   import alu_pkg::*;

   logic    dec_valid;
   alu_op_t dec_op;
   alu_op_t head_op;
   logic    queue_not_empty;
   logic    exec_pop;

   instr_decoder instr_decoder_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .issue_i     (issue_i),
      .instr_i     (instr_i),
      .rs1_value_i (rs1_value_i),
      .rs2_value_i (rs2_value_i),
      .pc_i        (pc_i),
      .op_valid_o  (dec_valid),
      .op_o        (dec_op)
   );

   op_queue #(
      .queue_depth (queue_depth)
   ) op_queue_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (dec_valid),
      .push_data_i (dec_op),
      .pop_i       (exec_pop),
      .head_o      (head_op),
      .not_empty_o (queue_not_empty),
      .full_o      (full_o)
   );

   alu_exec alu_exec_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .op_i           (head_op),
      .op_present_i   (queue_not_empty),
      .pop_o          (exec_pop),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

endmodule

`default_nettype wire

// ==== source/alu_exec.sv ====
`default_nettype none

module alu_exec (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  alu_pkg::alu_op_t     op_i,
   input  logic                 op_present_i,
   output logic                 pop_o,
   output logic                 result_valid_o,
   output alu_pkg::alu_result_t result_o
);
   import alu_pkg::*;

   logic [xlen-1:0]   a;
   logic [xlen-1:0]   b;
   logic [xlen-1:0]   imm;
   logic [xlen-1:0]   pc;
   logic [4:0]        shamt_r;
   logic [4:0]        shamt_i;

   logic              mul_a_signed;
   logic              mul_b_signed;
   logic [2*xlen-1:0] mul_a;
   logic [2*xlen-1:0] mul_b;
   logic [2*xlen-1:0] product;

   logic              div_by_zero;
   logic              div_overflow;
   logic [xlen-1:0]   divisor_s;
   logic [xlen-1:0]   divisor_u;
   logic [xlen-1:0]   quot_s;
   logic [xlen-1:0]   rem_s;
   logic [xlen-1:0]   quot_u;
   logic [xlen-1:0]   rem_u;

   logic [xlen-1:0]   result_d;
   logic [xlen-1:0]   target_d;
   logic [xlen-1:0]   result_q;
   logic [xlen-1:0]   target_q;
   logic              equal_q;
   logic              greater_q;

   assign a       = op_i.operand_a;
   assign b       = op_i.operand_b;
   assign imm     = op_i.imm;
   assign pc      = op_i.pc;
   assign shamt_r = b[4:0];
   assign shamt_i = imm[4:0];

   // the ALU takes one operation per cycle, so it pops whenever one is waiting
   assign pop_o = op_present_i;

   // one 64 bit multiplier; operand extension selects the signed flavour
   assign mul_a_signed = (op_i.opcode == op_mulh) || (op_i.opcode == op_mulhsu);
   assign mul_b_signed = (op_i.opcode == op_mulh);
   assign mul_a        = {{xlen{mul_a_signed & a[xlen-1]}}, a};
   assign mul_b        = {{xlen{mul_b_signed & b[xlen-1]}}, b};
   assign product      = mul_a * mul_b;

   assign div_by_zero  = (b == '0);
   assign div_overflow = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
   // dividing by one gives quotient a and remainder 0, the rv32 overflow result
   assign divisor_s    = (div_by_zero || div_overflow) ? xlen'(1) : b;
   assign divisor_u    = div_by_zero ? xlen'(1) : b;
   assign quot_s       = $signed(a) / $signed(divisor_s);
   assign rem_s        = $signed(a) % $signed(divisor_s);
   assign quot_u       = a / divisor_u;
   assign rem_u        = a % divisor_u;

   always_comb begin
      result_d = '0;
      target_d = target_q;
      case (op_i.opcode)
         op_add:    result_d = a + b;
         op_addi:   result_d = a + imm;
         op_sub:    result_d = a - b;
         op_mul:    result_d = product[xlen-1:0];
         op_mulh,
         op_mulhsu,
         op_mulhu:  result_d = product[2*xlen-1:xlen];
         op_div:    result_d = div_by_zero ? '1 : quot_s;
         op_divu:   result_d = div_by_zero ? '1 : quot_u;
         op_rem:    result_d = div_by_zero ? a : rem_s;
         op_remu:   result_d = div_by_zero ? a : rem_u;
         op_lui:    result_d = imm;
         op_auipc:  result_d = pc + imm;
         op_jal: begin
            result_d = pc + xlen'(4);
            target_d = pc + imm;
         end
         op_jalr: begin
            result_d = pc + xlen'(4);
            target_d = (a + imm) & ~xlen'(1);
         end
         op_mem:    result_d = a + imm;
         op_and:    result_d = a & b;
         op_andi:   result_d = a & imm;
         op_or:     result_d = a | b;
         op_ori:    result_d = a | imm;
         op_xor:    result_d = a ^ b;
         op_xori:   result_d = a ^ imm;
         op_sll:    result_d = a << shamt_r;
         op_slli:   result_d = a << shamt_i;
         op_srl:    result_d = a >> shamt_r;
         op_srli:   result_d = a >> shamt_i;
         op_sra:    result_d = $signed(a) >>> shamt_r;
         op_srai:   result_d = $signed(a) >>> shamt_i;
         op_slt:    result_d = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         op_slti:   result_d = {{(xlen-1){1'b0}}, $signed(a) < $signed(imm)};
         op_sltu:   result_d = {{(xlen-1){1'b0}}, a < b};
         op_sltiu:  result_d = {{(xlen-1){1'b0}}, a < imm};
         default:   result_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         result_valid_o <= 1'b0;
         target_q       <= '0;
      end else begin
         result_valid_o <= pop_o;
         if (pop_o) begin
            target_q <= target_d;
         end
      end
   end

   // flags are captured with the result so they match the popped operands
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         result_q  <= result_d;
         equal_q   <= (a == b);
         greater_q <= (a > b);
      end
   end

   assign result_o.result  = result_q;
   assign result_o.target  = target_q;
   assign result_o.equal   = equal_q;
   assign result_o.greater = greater_q;

endmodule

`default_nettype wire

// ==== source/op_queue.sv ====
`default_nettype none

module op_queue #(
   parameter int unsigned queue_depth = 4
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             push_i,
   input  alu_pkg::alu_op_t push_data_i,
   input  logic             pop_i,
   output alu_pkg::alu_op_t head_o,
   output logic             not_empty_o,
   output logic             full_o
);
   import alu_pkg::*;

   localparam int unsigned ptr_w = $clog2(queue_depth);
   localparam logic [ptr_w:0] depth_c = (ptr_w + 1)'(queue_depth);

   alu_op_t          mem [queue_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             do_push;
   logic             do_pop;

   assign not_empty_o = (count != '0);
   assign full_o      = (count == depth_c);
   // a push into a full queue is dropped
   assign do_push     = push_i && !full_o;
   assign do_pop      = pop_i && not_empty_o;
   assign head_o      = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     issue_i,
   input  logic [alu_pkg::xlen-1:0] instr_i,
   input  logic [alu_pkg::xlen-1:0] rs1_value_i,
   input  logic [alu_pkg::xlen-1:0] rs2_value_i,
   input  logic [alu_pkg::xlen-1:0] pc_i,
   output logic                     op_valid_o,
   output alu_pkg::alu_op_t         op_o
);
   import alu_pkg::*;

   logic [6:0]      major;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [xlen-1:0] imm_i_fmt;
   logic [xlen-1:0] imm_s_fmt;
   logic [xlen-1:0] imm_u_fmt;
   logic [xlen-1:0] imm_j_fmt;
   alu_opcode_e     opcode_d;
   logic [xlen-1:0] imm_d;

   assign major  = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   // u format is already shifted into the upper bits
   assign imm_u_fmt = {instr_i[31:12], 12'b0};
   assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

   always_comb begin
      opcode_d = op_illegal;
      imm_d    = '0;
      case (major)
         opc_lui: begin
            opcode_d = op_lui;
            imm_d    = imm_u_fmt;
         end
         opc_auipc: begin
            opcode_d = op_auipc;
            imm_d    = imm_u_fmt;
         end
         opc_jal: begin
            opcode_d = op_jal;
            imm_d    = imm_j_fmt;
         end
         opc_jalr: begin
            imm_d = imm_i_fmt;
            if (funct3 == 3'b000) begin
               opcode_d = op_jalr;
            end
         end
         opc_load: begin
            imm_d = imm_i_fmt;
            // lb lh lw lbu lhu
            if (funct3 != 3'b011 && funct3 < 3'b110) begin
               opcode_d = op_mem;
            end
         end
         opc_store: begin
            imm_d = imm_s_fmt;
            if (funct3 < 3'b011) begin
               opcode_d = op_mem;
            end
         end
         opc_op_imm: begin
            imm_d = imm_i_fmt;
            case (funct3)
               f3_add:  opcode_d = op_addi;
               f3_slt:  opcode_d = op_slti;
               f3_sltu: opcode_d = op_sltiu;
               f3_xor:  opcode_d = op_xori;
               f3_or:   opcode_d = op_ori;
               f3_and:  opcode_d = op_andi;
               f3_sll: begin
                  if (funct7 == f7_base) opcode_d = op_slli;
               end
               f3_srl: begin
                  if (funct7 == f7_base) opcode_d = op_srli;
                  else if (funct7 == f7_alt) opcode_d = op_srai;
               end
            endcase
         end
         opc_op: begin
            if (funct7 == f7_base) begin
               case (funct3)
                  f3_add:  opcode_d = op_add;
                  f3_sll:  opcode_d = op_sll;
                  f3_slt:  opcode_d = op_slt;
                  f3_sltu: opcode_d = op_sltu;
                  f3_xor:  opcode_d = op_xor;
                  f3_srl:  opcode_d = op_srl;
                  f3_or:   opcode_d = op_or;
                  f3_and:  opcode_d = op_and;
               endcase
            end else if (funct7 == f7_alt) begin
               if (funct3 == f3_add) opcode_d = op_sub;
               else if (funct3 == f3_srl) opcode_d = op_sra;
            end else if (funct7 == f7_muldiv) begin
               case (funct3)
                  f3_mul:    opcode_d = op_mul;
                  f3_mulh:   opcode_d = op_mulh;
                  f3_mulhsu: opcode_d = op_mulhsu;
                  f3_mulhu:  opcode_d = op_mulhu;
                  f3_div:    opcode_d = op_div;
                  f3_divu:   opcode_d = op_divu;
                  f3_rem:    opcode_d = op_rem;
                  f3_remu:   opcode_d = op_remu;
               endcase
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         op_valid_o <= 1'b0;
      end else begin
         op_valid_o <= issue_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue_i) begin
         op_o.opcode    <= opcode_d;
         op_o.operand_a <= rs1_value_i;
         op_o.operand_b <= rs2_value_i;
         op_o.imm       <= imm_d;
         op_o.pc        <= pc_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

   localparam int unsigned xlen = 32;

   typedef enum logic [5:0] {
      op_add,
      op_addi,
      op_sub,
      op_mul,
      op_mulh,
      op_mulhsu,
      op_mulhu,
      op_div,
      op_divu,
      op_rem,
      op_remu,
      op_lui,
      op_auipc,
      op_jal,
      op_jalr,
      op_mem,
      op_and,
      op_andi,
      op_or,
      op_ori,
      op_xor,
      op_xori,
      op_sll,
      op_slli,
      op_srl,
      op_srli,
      op_sra,
      op_srai,
      op_slt,
      op_slti,
      op_sltu,
      op_sltiu,
      op_illegal
   } alu_opcode_e;

   // one decoded operation as it travels through the queue
   typedef struct packed {
      alu_opcode_e     opcode;
      logic [xlen-1:0] operand_a;
      logic [xlen-1:0] operand_b;
      logic [xlen-1:0] imm;
      logic [xlen-1:0] pc;
   } alu_op_t;

   typedef struct packed {
      logic [xlen-1:0] result;
      logic [xlen-1:0] target;
      logic            equal;
      logic            greater;
   } alu_result_t;

   // rv32 major opcodes
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;

   // funct3 of the base integer group
   localparam logic [2:0] f3_add  = 3'b000;
   localparam logic [2:0] f3_sll  = 3'b001;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_srl  = 3'b101;
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // funct3 of the M extension
   localparam logic [2:0] f3_mul    = 3'b000;
   localparam logic [2:0] f3_mulh   = 3'b001;
   localparam logic [2:0] f3_mulhsu = 3'b010;
   localparam logic [2:0] f3_mulhu  = 3'b011;
   localparam logic [2:0] f3_div    = 3'b100;
   localparam logic [2:0] f3_divu   = 3'b101;
   localparam logic [2:0] f3_rem    = 3'b110;
   localparam logic [2:0] f3_remu   = 3'b111;

   localparam logic [6:0] f7_base   = 7'b0000000;
   localparam logic [6:0] f7_alt    = 7'b0100000;
   localparam logic [6:0] f7_muldiv = 7'b0000001;

endpackage

`default_nettype wire
